//--- rtl/msg_pkg.sv
package msg_pkg;

  // Host word width on both streams
  localparam int word_w = 32;

  typedef enum logic [7:0] {
    OP_COEFF = 8'd1,
    OP_BLOCK = 8'd2,
    OP_END   = 8'd255
  } opcode_e;

  // End of stream marker sent by the host
  localparam logic [word_w-1:0] end_word = '1;

  //****************************************
  // Two views of one host word
  //****************************************

  // Header view, valid while no block is open
  typedef struct packed {
    logic [7:0]         opcode;
    logic [7:0]         index;
    logic signed [15:0] value;
  } hdr_t;

  // Data view, valid inside a block
  typedef struct packed {
    logic signed [15:0] sample_hi;
    logic signed [15:0] sample_lo;
  } smp_t;

  typedef union packed {
    hdr_t hdr;
    smp_t smp;
  } host_word_u;

endpackage

//--- rtl/proc_pkg.sv
package proc_pkg;

  // Operation kinds inside the pipeline
  typedef enum logic [1:0] {
    K_COEFF,
    K_DATA,
    K_END
  } op_kind_e;

  typedef logic signed [15:0] coeff_t;

  // Decoded operation, fields used per kind
  typedef struct packed {
    op_kind_e           kind;
    logic [7:0]         index;
    logic [15:0]        value;
    logic signed [15:0] sample_hi;
    logic signed [15:0] sample_lo;
  } dec_op_t;

  // Only K_DATA and K_END get here
  typedef struct packed {
    op_kind_e    kind;
    logic [31:0] value;
  } result_t;

endpackage

//--- rtl/msg_fifo.sv
`timescale 1ns/100ps

module msg_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                       bus_clk,
  input  logic                       rst,
  input  logic [msg_pkg::word_w-1:0] din,
  input  logic                       wr_en,
  output logic                       full,
  output logic [msg_pkg::word_w-1:0] dout,
  input  logic                       rd_en,
  output logic                       empty
);

  localparam int addr_w = $clog2(FIFO_DEPTH);

  logic [msg_pkg::word_w-1:0] mem [FIFO_DEPTH];
  logic [addr_w-1:0]          wr_ptr;
  logic [addr_w-1:0]          rd_ptr;
  logic [addr_w:0]            count;
  logic                       do_wr;
  logic                       do_rd;

  // Overflowing writes and underflowing reads are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == (addr_w + 1)'(FIFO_DEPTH));
  assign empty = (count == '0);

  // Show-ahead output, head word is always on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/msg_decode.sv
`timescale 1ns/100ps

module msg_decode #(
  parameter int NUM_COEFF = 4
) (
  input  logic                       bus_clk,
  input  logic                       rst,
  input  logic [msg_pkg::word_w-1:0] in_word,
  input  logic                       in_empty,
  output logic                       in_pop,
  output proc_pkg::dec_op_t          dec_op,
  output logic                       dec_valid,
  input  logic                       exec_ready
);

  localparam logic [7:0] idx_mask = 8'(NUM_COEFF - 1);

  msg_pkg::host_word_u w;
  proc_pkg::dec_op_t   nxt_op;
  logic                emit;
  logic                take;
  logic                is_end;
  logic [15:0]         blk_cnt;
  logic [7:0]          blk_idx;
  logic                stopped;

  assign w      = in_word;
  assign is_end = (in_word == msg_pkg::end_word);

  // Output register is free or draining this cycle
  assign take = !dec_valid || exec_ready;

  // After the end marker every word is drained and dropped
  assign in_pop = !in_empty && (stopped || take);

  //****************************************
  // Word classification
  //****************************************
  always_comb begin
    nxt_op = '0;
    emit   = 1'b0;
    if (blk_cnt != '0) begin
      nxt_op.kind      = proc_pkg::K_DATA;
      nxt_op.index     = blk_idx;
      nxt_op.sample_hi = w.smp.sample_hi;
      nxt_op.sample_lo = w.smp.sample_lo;
      emit             = !stopped;
    end else begin
      case (w.hdr.opcode)
        msg_pkg::OP_COEFF: begin
          nxt_op.kind  = proc_pkg::K_COEFF;
          nxt_op.index = w.hdr.index & idx_mask;
          nxt_op.value = w.hdr.value;
          emit         = !stopped;
        end
        msg_pkg::OP_END: begin
          // Opcode 255 alone is not enough, the whole word must match
          nxt_op.kind = proc_pkg::K_END;
          emit        = !stopped && is_end;
        end
        default: begin
          emit = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (in_pop && emit) begin
      dec_op <= nxt_op;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      blk_cnt   <= '0;
      blk_idx   <= '0;
      stopped   <= 1'b0;
    end else begin
      if (take) begin
        dec_valid <= in_pop && emit;
      end
      if (in_pop && !stopped) begin
        if (blk_cnt != '0) begin
          blk_cnt <= blk_cnt - 1'b1;
        end else if (w.hdr.opcode == msg_pkg::OP_BLOCK) begin
          blk_cnt <= w.hdr.value;
          blk_idx <= w.hdr.index & idx_mask;
        end else if (is_end) begin
          stopped <= 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/coeff_execute.sv
`timescale 1ns/100ps

module coeff_execute #(
  parameter int NUM_COEFF = 4
) (
  input  logic              bus_clk,
  input  logic              rst,
  input  proc_pkg::dec_op_t dec_op,
  input  logic              dec_valid,
  output logic              exec_ready,
  output proc_pkg::result_t res,
  output logic              res_valid,
  input  logic              res_ready
);

  localparam int idx_w = $clog2(NUM_COEFF);

  proc_pkg::coeff_t   coeff [NUM_COEFF];
  logic [idx_w-1:0]   lo_idx;
  logic [idx_w-1:0]   hi_idx;
  logic signed [31:0] prod_lo;
  logic signed [31:0] prod_hi;
  logic signed [31:0] sum;
  logic               xfer;
  logic               is_load;

  assign exec_ready = !res_valid || res_ready;
  assign xfer       = dec_valid && exec_ready;
  assign is_load    = (dec_op.kind == proc_pkg::K_COEFF);

  // Pair index wraps within the table
  assign lo_idx = dec_op.index[idx_w-1:0];
  assign hi_idx = lo_idx + 1'b1;

  //****************************************
  // Two-product reduction
  //****************************************
  assign prod_lo = dec_op.sample_lo * coeff[lo_idx];
  assign prod_hi = dec_op.sample_hi * coeff[hi_idx];
  // Sum wraps at 32 bits
  assign sum     = prod_lo + prod_hi;

  always_ff @(posedge bus_clk) begin
    if (xfer && !is_load) begin
      res.kind  <= dec_op.kind;
      res.value <= (dec_op.kind == proc_pkg::K_DATA) ? sum : '0;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      for (int i = 0; i < NUM_COEFF; i++) begin
        coeff[i] <= '0;
      end
    end else begin
      if (exec_ready) begin
        res_valid <= xfer && !is_load;
      end
      // Loads only touch the table
      if (xfer && is_load) begin
        coeff[lo_idx] <= dec_op.value;
      end
    end
  end

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/100ps

module result_stage (
  input  logic                       bus_clk,
  input  logic                       rst,
  input  proc_pkg::result_t          res,
  input  logic                       res_valid,
  output logic                       res_ready,
  output logic [msg_pkg::word_w-1:0] out_data,
  output logic                       out_wr,
  input  logic                       out_full,
  input  logic                       out_empty,
  output logic                       eof
);

  logic end_seen;

  // Outbound queue space decides the handshake
  assign res_ready = !out_full;

  assign out_data = res.value;
  assign out_wr   = res_valid && !out_full && (res.kind == proc_pkg::K_DATA);

  // End reaches the host once the queue has drained
  assign eof = end_seen && out_empty;

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      end_seen <= 1'b0;
    end else if (res_valid && res_ready && (res.kind == proc_pkg::K_END)) begin
      end_seen <= 1'b1;
    end
  end

endmodule

//--- rtl/reducer_top.sv
`timescale 1ns/100ps

module reducer_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int NUM_COEFF  = 4
) (
  input  logic                       bus_clk,
  input  logic                       rst,
  input  logic [msg_pkg::word_w-1:0] wr_data,
  input  logic                       wr_en,
  output logic                       wr_full,
  output logic [msg_pkg::word_w-1:0] rd_data,
  input  logic                       rd_en,
  output logic                       rd_empty,
  output logic                       rd_eof
);

  logic [msg_pkg::word_w-1:0] in_word;
  logic                       in_empty;
  logic                       in_pop;
  proc_pkg::dec_op_t          dec_op;
  logic                       dec_valid;
  logic                       exec_ready;
  proc_pkg::result_t          res;
  logic                       res_valid;
  logic                       res_ready;
  logic [msg_pkg::word_w-1:0] out_data;
  logic                       out_wr;
  logic                       out_full;

  //****************************************
  // Host to pipeline
  //****************************************
  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .din     (wr_data),
    .wr_en   (wr_en),
    .full    (wr_full),
    .dout    (in_word),
    .rd_en   (in_pop),
    .empty   (in_empty)
  );

  msg_decode #(.NUM_COEFF(NUM_COEFF)) u_msg_decode (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .in_word    (in_word),
    .in_empty   (in_empty),
    .in_pop     (in_pop),
    .dec_op     (dec_op),
    .dec_valid  (dec_valid),
    .exec_ready (exec_ready)
  );

  coeff_execute #(.NUM_COEFF(NUM_COEFF)) u_coeff_execute (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .dec_op     (dec_op),
    .dec_valid  (dec_valid),
    .exec_ready (exec_ready),
    .res        (res),
    .res_valid  (res_valid),
    .res_ready  (res_ready)
  );

  result_stage u_result_stage (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .out_data  (out_data),
    .out_wr    (out_wr),
    .out_full  (out_full),
    .out_empty (rd_empty),
    .eof       (rd_eof)
  );

  //****************************************
  // Pipeline to host
  //****************************************
  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .din     (out_data),
    .wr_en   (out_wr),
    .full    (out_full),
    .dout    (rd_data),
    .rd_en   (rd_en),
    .empty   (rd_empty)
  );

endmodule

//--- tests/reducer_properties.sv
`timescale 1ns/100ps

module reducer_properties (
  input logic                       bus_clk,
  input logic                       rst,
  input logic [msg_pkg::word_w-1:0] rd_data,
  input logic                       rd_en,
  input logic                       rd_empty,
  input logic                       rd_eof
);

  // Head of the outbound queue holds until popped
  assert property (@(posedge bus_clk) disable iff (rst)
    (!rd_empty && !rd_en) |=> $stable(rd_data))
    else $error("rd_data changed while no pop was requested");

  assert property (@(posedge bus_clk) disable iff (rst) rd_eof |-> rd_empty)
    else $error("rd_eof high with words still queued");

  // End flag is sticky until reset
  assert property (@(posedge bus_clk) disable iff (rst) rd_eof |=> rd_eof)
    else $error("rd_eof fell without a reset");

endmodule

bind reducer_top reducer_properties u_reducer_properties (
  .bus_clk  (bus_clk),
  .rst      (rst),
  .rd_data  (rd_data),
  .rd_en    (rd_en),
  .rd_empty (rd_empty),
  .rd_eof   (rd_eof)
);

//--- tests/tb_reducer.sv
`timescale 1ns/100ps

module tb_reducer;

  localparam int          fifo_depth   = 16;
  localparam int          num_coeff    = 4;
  localparam int          stream_limit = 3000;
  localparam int          eof_limit    = 200;
  localparam logic [7:0]  op_coeff     = 8'd1;
  localparam logic [7:0]  op_block     = 8'd2;
  localparam logic [31:0] stop_word    = 32'hffff_ffff;

  logic               bus_clk;
  logic               rst;
  logic [31:0]        wr_data;
  logic               wr_en;
  logic               wr_full;
  logic [31:0]        rd_data;
  logic               rd_en;
  logic               rd_empty;
  logic               rd_eof;

  logic [31:0]        lfsr;
  logic [31:0]        stim_q [$];
  logic [31:0]        exp_q [$];
  logic signed [15:0] m_coeff [num_coeff];
  logic [15:0]        m_cnt;
  int                 m_idx;
  bit                 m_stopped;
  int                 errors;
  int                 checks;
  int                 n_tests;
  int                 test_err;
  bit                 aborted;
  bit                 saw_full;

  reducer_top #(
    .FIFO_DEPTH (fifo_depth),
    .NUM_COEFF  (num_coeff)
  ) u_reducer_top (
    .bus_clk  (bus_clk),
    .rst      (rst),
    .wr_data  (wr_data),
    .wr_en    (wr_en),
    .wr_full  (wr_full),
    .rd_data  (rd_data),
    .rd_en    (rd_en),
    .rd_empty (rd_empty),
    .rd_eof   (rd_eof)
  );

  always #50 bus_clk = ~bus_clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  //****************************************
  // Reference model of the host protocol
  //****************************************
  task automatic model_word(input logic [31:0] word);
    msg_pkg::host_word_u u;
    int                  acc;
    u = word;
    if (m_stopped) begin
      // Everything after the end marker is dropped
    end else if (m_cnt != 0) begin
      acc = int'(u.smp.sample_lo) * int'(m_coeff[m_idx])
          + int'(u.smp.sample_hi) * int'(m_coeff[(m_idx + 1) % num_coeff]);
      exp_q.push_back(acc);
      m_cnt--;
    end else if (word == stop_word) begin
      m_stopped = 1'b1;
    end else if (u.hdr.opcode == op_coeff) begin
      m_coeff[int'(u.hdr.index) % num_coeff] = u.hdr.value;
    end else if (u.hdr.opcode == op_block) begin
      m_cnt = u.hdr.value;
      m_idx = int'(u.hdr.index) % num_coeff;
    end
  endtask

  task automatic push_word(input logic [31:0] word);
    stim_q.push_back(word);
    model_word(word);
  endtask

  task automatic add_coeff(input logic [7:0] idx, input logic [15:0] val);
    push_word({op_coeff, idx, val});
  endtask

  task automatic add_block(input logic [7:0] idx, input int len);
    push_word({op_block, idx, 16'(len)});
    for (int i = 0; i < len; i++) begin
      push_word(rand_bits(32));
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge bus_clk);
      #10;
      check_value("rd_empty", 32'(rd_empty), 32'd1);
    end
  endtask

  //****************************************
  // Host side writer and reader
  //****************************************
  task automatic run_stream(input bit hold_reader);
    int          cyc;
    bit          reading;
    logic [31:0] got;
    cyc      = 0;
    reading  = !hold_reader;
    saw_full = 1'b0;
    while ((stim_q.size() != 0 || exp_q.size() != 0) && cyc < stream_limit) begin
      @(posedge bus_clk);
      #10;
      cyc++;
      // A stalled reader resumes once the inbound queue is full
      if (wr_full) begin
        saw_full = 1'b1;
        reading  = 1'b1;
      end
      wr_en = 1'b0;
      if (stim_q.size() != 0 && !wr_full && rand_bits(2) != 0) begin
        wr_data = stim_q.pop_front();
        wr_en   = 1'b1;
      end
      rd_en = 1'b0;
      if (reading && !rd_empty && rand_bits(1) == 1) begin
        rd_en = 1'b1;
        got   = rd_data;
        assert (exp_q.size() != 0) else begin
          $display("ERROR t=%0t output word %h arrived when none was expected", $time, got);
          errors++;
        end
        if (exp_q.size() != 0) begin
          check_value("rd_data", got, exp_q.pop_front());
        end
      end
    end
    @(posedge bus_clk);
    #10;
    wr_en = 1'b0;
    rd_en = 1'b0;
    assert (stim_q.size() == 0 && exp_q.size() == 0) else begin
      $display("ERROR t=%0t stream did not drain within %0d cycles", $time, stream_limit);
      errors++;
      aborted = 1'b1;
    end
    if (!aborted) begin
      expect_quiet(12);
    end
  endtask

  task automatic wait_eof();
    int cyc;
    cyc = 0;
    while (rd_eof !== 1'b1 && cyc < eof_limit) begin
      @(posedge bus_clk);
      #10;
      cyc++;
    end
    assert (rd_eof === 1'b1) else begin
      $display("ERROR t=%0t rd_eof did not rise within %0d cycles", $time, eof_limit);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, errors - test_err);
    test_err = errors;
  endtask

  initial begin
    bus_clk   = 1'b0;
    rst       = 1'b1;
    wr_data   = '0;
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    lfsr      = 32'hb6a6;
    errors    = 0;
    checks    = 0;
    n_tests   = 0;
    test_err  = 0;
    aborted   = 1'b0;
    saw_full  = 1'b0;
    m_cnt     = '0;
    m_idx     = 0;
    m_stopped = 1'b0;
    for (int i = 0; i < num_coeff; i++) begin
      m_coeff[i] = '0;
    end
    repeat (5) @(posedge bus_clk);
    #10;
    rst = 1'b0;

    // Idle flags, then a block against the cleared table
    check_value("rd_empty", 32'(rd_empty), 32'd1);
    check_value("rd_eof", 32'(rd_eof), 32'd0);
    check_value("wr_full", 32'(wr_full), 32'd0);
    add_block(8'd1, 3);
    run_stream(1'b0);
    end_test("reset state");

    if (!aborted) begin
      for (int i = 0; i < num_coeff; i++) begin
        add_coeff(8'(i), 16'(rand_bits(16)));
      end
      for (int i = 0; i < num_coeff; i++) begin
        add_block(8'(i), int'(rand_bits(3)) + 1);
      end
      // Indexes above the table size wrap
      add_coeff(8'd5, 16'(rand_bits(16)));
      add_block(8'd7, int'(rand_bits(3)) + 1);
      add_block(8'd6, int'(rand_bits(3)) + 1);
      run_stream(1'b0);
      end_test("loads and blocks");
    end

    if (!aborted) begin
      push_word({8'h07, 8'h01, 16'h1234});
      push_word(32'hff00_0000);
      push_word({op_block, 8'd2, 16'd0});
      push_word({op_block, 8'd3, 16'd3});
      push_word({op_coeff, 8'd0, 16'h7fff});
      push_word(stop_word);
      push_word({op_block, 8'd1, 16'd9});
      run_stream(1'b0);
      end_test("ignored headers");
    end

    if (!aborted) begin
      add_coeff(8'd2, 16'(rand_bits(16)));
      add_coeff(8'd3, 16'(rand_bits(16)));
      add_block(8'd2, 48);
      run_stream(1'b1);
      check_value("wr_full seen", 32'(saw_full), 32'd1);
      end_test("back-pressure");
    end

    if (!aborted) begin
      add_coeff(8'd3, 16'(rand_bits(16)));
      add_block(8'd3, 4);
      push_word(stop_word);
      add_coeff(8'd0, 16'h0100);
      add_block(8'd0, 2);
      run_stream(1'b0);
      if (!aborted) begin
        wait_eof();
        check_value("rd_empty", 32'(rd_empty), 32'd1);
        expect_quiet(20);
        check_value("rd_eof", 32'(rd_eof), 32'd1);
      end
      end_test("end of stream");
    end

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
rtl/msg_pkg.sv
rtl/proc_pkg.sv
rtl/msg_fifo.sv
rtl/msg_decode.sv
rtl/coeff_execute.sv
rtl/result_stage.sv
rtl/reducer_top.sv
tests/reducer_properties.sv
tests/tb_reducer.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_reducer
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Result: FAILED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); test $$st -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
